// File: src/flight_pkg.sv
package flight_pkg;

	// Q12.4 two's complement for angles, rates and errors
	typedef logic signed [15:0] fixed_t;

	// raw receiver channel
	typedef logic [7:0] rx_val_t;

	// yaw heading, four times finer than the IMU yaw
	typedef logic [15:0] heading_t;

	typedef struct packed {
		rx_val_t throttle;
		rx_val_t yaw;
		rx_val_t pitch;
		rx_val_t roll;
	} rx_targets_t;

	// yaw runs 0 to ANGLE_360
	typedef struct packed {
		fixed_t yaw;
		fixed_t pitch;
		fixed_t roll;
	} attitude_t;

	typedef struct packed {
		fixed_t yaw;
		fixed_t pitch;
		fixed_t roll;
	} angle_err_t;

	typedef struct packed {
		fixed_t     throttle;
		fixed_t     yaw;
		fixed_t     pitch;
		fixed_t     roll;
		angle_err_t errors;
	} rate_set_t;

	typedef struct packed {
		fixed_t yaw;
		fixed_t pitch;
		fixed_t roll;
	} gyro_t;

	typedef struct packed {
		fixed_t throttle;
		fixed_t yaw;
		fixed_t pitch;
		fixed_t roll;
	} rate_cmd_t;

	// 360 deg in Q12.4 units of the IMU
	localparam int ANGLE_360 = 5760;
	localparam int ANGLE_270 = 4320;
	localparam int ANGLE_90 = 1440;
	localparam int HEADING_SCALE_SHIFT = 2;

	// 100 deg/s
	localparam int RATE_LIMIT = 1600;
	localparam int THROTTLE_LIMIT = 4000;
	// receiver units
	localparam int THROTTLE_IDLE = 10;
	localparam int MAP_OFFSET = 500;
	localparam int YAW_CENTER = 125;
	localparam int FIXED_MAX = 32767;

	typedef enum logic [2:0] {
		WAITING,
		MAPPING,
		SCALING,
		LIMITING,
		COMPLETE
	} ctl_state_e;

	// (val * mult) >>> shift, clamped to +-limit
	function automatic fixed_t scale_sat(
		input logic signed [31:0] val,
		input int mult,
		input int shift,
		input int limit
	);
		logic signed [47:0] wide;
		wide = val;
		wide = wide * mult;
		wide = wide >>> shift;
		if (wide > limit)
			return fixed_t'(limit);
		else if (wide < -limit)
			return fixed_t'(-limit);
		else
			return fixed_t'(wide);
	endfunction

endpackage

// File: src/angle_controller.sv
`timescale 1ns/100ps

module angle_controller #(
	parameter int ANGLE_MULT = 3,
	parameter int ANGLE_SHIFT = 2
) (
	input  logic                    us_clk,
	input  logic                    resetn,
	input  logic                    frame_valid,
	output logic                    frame_ready,
	input  flight_pkg::rx_targets_t targets,
	input  flight_pkg::attitude_t   angles,
	output logic                    sp_valid,
	input  logic                    sp_ready,
	output flight_pkg::rate_set_t   setpoint
);

	// one full turn of the tracked heading
	localparam int HEADING_FULL = flight_pkg::ANGLE_360 <<< flight_pkg::HEADING_SCALE_SHIFT;

	flight_pkg::ctl_state_e  state;
	flight_pkg::ctl_state_e  next_state;
	flight_pkg::rx_targets_t lat_targets;
	flight_pkg::attitude_t   lat_angles;
	flight_pkg::heading_t    heading;
	flight_pkg::heading_t    heading_next;
	flight_pkg::angle_err_t  map_err;
	flight_pkg::angle_err_t  map_err_next;
	flight_pkg::angle_err_t  scaled_err;
	flight_pkg::fixed_t      map_thr;
	flight_pkg::fixed_t      thr_lim;
	logic                    accept;

	int heading_step;
	int yaw_tgt;
	int yaw_act;
	int yaw_raw;
	int pitch_raw;
	int roll_raw;

	assign frame_ready = (state == flight_pkg::WAITING);
	assign sp_valid = (state == flight_pkg::COMPLETE);
	assign accept = frame_valid && frame_ready;

	always_comb begin
		case (state)
			flight_pkg::WAITING:
				next_state = accept ? flight_pkg::MAPPING : flight_pkg::WAITING;
			flight_pkg::MAPPING:
				next_state = flight_pkg::SCALING;
			flight_pkg::SCALING:
				next_state = flight_pkg::LIMITING;
			flight_pkg::LIMITING:
				next_state = flight_pkg::COMPLETE;
			flight_pkg::COMPLETE:
				next_state = sp_ready ? flight_pkg::WAITING : flight_pkg::COMPLETE;
			default:
				next_state = flight_pkg::WAITING;
		endcase
	end

	// heading follows the incoming frame, taken on the accepting edge
	always_comb begin
		heading_step = int'(heading) + int'(targets.yaw) - flight_pkg::YAW_CENTER;
		if (targets.throttle < flight_pkg::THROTTLE_IDLE)
			// motors idle so lock onto the measured yaw
			heading_next = flight_pkg::heading_t'(int'(angles.yaw) <<<
				flight_pkg::HEADING_SCALE_SHIFT);
		else if (heading_step >= HEADING_FULL)
			heading_next = flight_pkg::heading_t'(heading_step - HEADING_FULL);
		else if (heading_step < 0)
			heading_next = flight_pkg::heading_t'(heading_step + HEADING_FULL);
		else
			heading_next = flight_pkg::heading_t'(heading_step);
	end

	always_comb begin
		yaw_tgt = int'(heading) >>> flight_pkg::HEADING_SCALE_SHIFT;
		yaw_act = int'(lat_angles.yaw);
		// shortest way round across the 0/360 seam
		if ((yaw_tgt > flight_pkg::ANGLE_270) && (yaw_act < flight_pkg::ANGLE_90))
			yaw_raw = yaw_tgt - yaw_act - flight_pkg::ANGLE_360;
		else if ((yaw_act > flight_pkg::ANGLE_270) && (yaw_tgt < flight_pkg::ANGLE_90))
			yaw_raw = yaw_tgt - yaw_act + flight_pkg::ANGLE_360;
		else
			yaw_raw = yaw_tgt - yaw_act;
		pitch_raw = (int'(lat_targets.pitch) <<< 2) - flight_pkg::MAP_OFFSET -
			int'(lat_angles.pitch);
		// IMU roll is inverted, so add it
		roll_raw = (int'(lat_targets.roll) <<< 2) - flight_pkg::MAP_OFFSET +
			int'(lat_angles.roll);
		map_err_next.yaw = flight_pkg::scale_sat(yaw_raw, 1, 0, flight_pkg::FIXED_MAX);
		map_err_next.pitch = flight_pkg::scale_sat(pitch_raw, 1, 0, flight_pkg::FIXED_MAX);
		map_err_next.roll = flight_pkg::scale_sat(roll_raw, 1, 0, flight_pkg::FIXED_MAX);
	end

	always_comb begin
		if (map_thr > flight_pkg::THROTTLE_LIMIT)
			thr_lim = flight_pkg::fixed_t'(flight_pkg::THROTTLE_LIMIT);
		else if (map_thr < 0)
			thr_lim = '0;
		else
			thr_lim = map_thr;
	end

	// working registers of the datapath
	always_ff @(posedge us_clk) begin
		if (accept) begin
			lat_targets <= targets;
			lat_angles <= angles;
		end
		if (state == flight_pkg::MAPPING) begin
			map_err <= map_err_next;
			// receiver units straight into Q12.4
			map_thr <= flight_pkg::fixed_t'({4'b0000, lat_targets.throttle, 4'b0000});
		end
		if (state == flight_pkg::SCALING) begin
			scaled_err.yaw <= flight_pkg::scale_sat(map_err.yaw, ANGLE_MULT, ANGLE_SHIFT,
				flight_pkg::FIXED_MAX);
			scaled_err.pitch <= flight_pkg::scale_sat(map_err.pitch, ANGLE_MULT, ANGLE_SHIFT,
				flight_pkg::FIXED_MAX);
			scaled_err.roll <= flight_pkg::scale_sat(map_err.roll, ANGLE_MULT, ANGLE_SHIFT,
				flight_pkg::FIXED_MAX);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= flight_pkg::WAITING;
			heading <= '0;
			setpoint <= '0;
		end else begin
			state <= next_state;
			if (accept)
				heading <= heading_next;
			if (state == flight_pkg::LIMITING) begin
				setpoint.throttle <= thr_lim;
				setpoint.yaw <= flight_pkg::scale_sat(scaled_err.yaw, 1, 0,
					flight_pkg::RATE_LIMIT);
				setpoint.pitch <= flight_pkg::scale_sat(scaled_err.pitch, 1, 0,
					flight_pkg::RATE_LIMIT);
				setpoint.roll <= flight_pkg::scale_sat(scaled_err.roll, 1, 0,
					flight_pkg::RATE_LIMIT);
				setpoint.errors <= map_err;
			end
		end
	end

	a_sp_hold: assert property (@(posedge us_clk) disable iff (!resetn)
		sp_valid && !sp_ready |=> sp_valid && $stable(setpoint))
		else $error("setpoint dropped or changed before sp_ready");

	a_state_legal: assert property (@(posedge us_clk) disable iff (!resetn)
		state inside {flight_pkg::WAITING, flight_pkg::MAPPING, flight_pkg::SCALING,
			flight_pkg::LIMITING, flight_pkg::COMPLETE})
		else $error("illegal controller state %0d", state);

endmodule

// File: src/gyro_rate_filter.sv
`timescale 1ns/100ps

module gyro_rate_filter #(
	parameter int AVG_LOG2 = 2
) (
	input  logic              us_clk,
	input  logic              resetn,
	input  logic              gyro_valid,
	input  flight_pkg::gyro_t gyro,
	output flight_pkg::gyro_t gyro_avg,
	output logic              gyro_primed
);

	localparam int DEPTH = 1 << AVG_LOG2;
	// room for DEPTH samples without overflow
	localparam int SUM_W = $bits(flight_pkg::fixed_t) + AVG_LOG2;

	typedef logic signed [SUM_W-1:0] sum_t;

	flight_pkg::gyro_t        hist [DEPTH];
	flight_pkg::fixed_t [2:0] sample;
	flight_pkg::fixed_t [2:0] oldest;
	flight_pkg::fixed_t [2:0] avg;
	sum_t                     sum [3];
	logic [AVG_LOG2-1:0]      wr_ptr;

	// axis view of the structs, yaw in the top slot
	assign sample = gyro;
	assign oldest = hist[wr_ptr];
	assign gyro_avg = avg;

	always_comb begin
		for (int i = 0; i < 3; i++)
			avg[i] = flight_pkg::fixed_t'(sum[i] >>> AVG_LOG2);
	end

	// history ring, slot at wr_ptr holds the oldest sample once full
	always_ff @(posedge us_clk) begin
		if (gyro_valid)
			hist[wr_ptr] <= gyro;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			gyro_primed <= 1'b0;
			for (int i = 0; i < 3; i++)
				sum[i] <= '0;
		end else if (gyro_valid) begin
			wr_ptr <= wr_ptr + 1'b1;
			// last slot written, window is full from here on
			if (&wr_ptr)
				gyro_primed <= 1'b1;
			for (int i = 0; i < 3; i++)
				sum[i] <= sum[i] + sum_t'($signed(sample[i])) -
					(gyro_primed ? sum_t'($signed(oldest[i])) : sum_t'(0));
		end
	end

	a_primed_sticky: assert property (@(posedge us_clk) disable iff (!resetn)
		gyro_primed |=> gyro_primed)
		else $error("gyro_primed fell after priming");

endmodule

// File: src/rate_loop.sv
`timescale 1ns/100ps

module rate_loop #(
	parameter int KP_MULT = 5,
	parameter int KP_SHIFT = 3,
	parameter int CMD_LIMIT = 2000
) (
	input  logic                   us_clk,
	input  logic                   resetn,
	input  logic                   sp_valid,
	output logic                   sp_ready,
	input  flight_pkg::rate_set_t  setpoint,
	input  flight_pkg::gyro_t      gyro_avg,
	input  logic                   gyro_primed,
	output logic                   cmd_valid,
	input  logic                   cmd_ready,
	output flight_pkg::rate_cmd_t  cmd,
	output flight_pkg::angle_err_t errors
);

	flight_pkg::rate_cmd_t cmd_next;
	logic                  load;

	// no commands until the gyro average is meaningful
	assign sp_ready = gyro_primed && (!cmd_valid || cmd_ready);
	assign load = sp_valid && sp_ready;

	// proportional term per axis
	always_comb begin
		cmd_next.throttle = setpoint.throttle;
		cmd_next.yaw = flight_pkg::scale_sat(int'(setpoint.yaw) - int'(gyro_avg.yaw),
			KP_MULT, KP_SHIFT, CMD_LIMIT);
		cmd_next.pitch = flight_pkg::scale_sat(int'(setpoint.pitch) - int'(gyro_avg.pitch),
			KP_MULT, KP_SHIFT, CMD_LIMIT);
		cmd_next.roll = flight_pkg::scale_sat(int'(setpoint.roll) - int'(gyro_avg.roll),
			KP_MULT, KP_SHIFT, CMD_LIMIT);
	end

	// single output slot
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			cmd_valid <= 1'b0;
			cmd <= '0;
			errors <= '0;
		end else if (load) begin
			cmd_valid <= 1'b1;
			cmd <= cmd_next;
			errors <= setpoint.errors;
		end else if (cmd_ready) begin
			cmd_valid <= 1'b0;
		end
	end

	a_cmd_hold: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd) && $stable(errors))
		else $error("cmd changed while stalled");

endmodule

// File: src/attitude_stabilizer.sv
`timescale 1ns/100ps

module attitude_stabilizer #(
	parameter int ANGLE_MULT = 3,
	parameter int ANGLE_SHIFT = 2,
	parameter int AVG_LOG2 = 2,
	parameter int KP_MULT = 5,
	parameter int KP_SHIFT = 3,
	parameter int CMD_LIMIT = 2000
) (
	input  logic                    us_clk,
	input  logic                    resetn,
	input  logic                    frame_valid,
	output logic                    frame_ready,
	input  flight_pkg::rx_targets_t targets,
	input  flight_pkg::attitude_t   angles,
	input  logic                    gyro_valid,
	input  flight_pkg::gyro_t       gyro,
	output logic                    cmd_valid,
	input  logic                    cmd_ready,
	output flight_pkg::rate_cmd_t   cmd,
	output flight_pkg::angle_err_t  errors
);

	logic                  sp_valid;
	logic                  sp_ready;
	flight_pkg::rate_set_t setpoint;
	flight_pkg::gyro_t     gyro_avg;
	logic                  gyro_primed;

	// outer angle loop
	angle_controller #(
		.ANGLE_MULT (ANGLE_MULT),
		.ANGLE_SHIFT(ANGLE_SHIFT)
	) u_angle (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.targets    (targets),
		.angles     (angles),
		.sp_valid   (sp_valid),
		.sp_ready   (sp_ready),
		.setpoint   (setpoint)
	);

	gyro_rate_filter #(
		.AVG_LOG2(AVG_LOG2)
	) u_gyro (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.gyro_valid (gyro_valid),
		.gyro       (gyro),
		.gyro_avg   (gyro_avg),
		.gyro_primed(gyro_primed)
	);

	// inner rate loop
	rate_loop #(
		.KP_MULT  (KP_MULT),
		.KP_SHIFT (KP_SHIFT),
		.CMD_LIMIT(CMD_LIMIT)
	) u_rate (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.sp_valid   (sp_valid),
		.sp_ready   (sp_ready),
		.setpoint   (setpoint),
		.gyro_avg   (gyro_avg),
		.gyro_primed(gyro_primed),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd        (cmd),
		.errors     (errors)
	);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic us_clk,
	output logic resetn
);

	// 4 ns period
	initial begin
		us_clk = 1'b0;
		forever #2 us_clk = ~us_clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (2) @(posedge us_clk);
		resetn = 1'b1;
	end

endmodule

// File: testbench/attitude_stabilizer_tb.sv
`timescale 1ns/100ps

module attitude_stabilizer_tb;

	localparam int ANGLE_MULT = 3;
	localparam int ANGLE_SHIFT = 2;
	localparam int AVG_LOG2 = 2;
	localparam int KP_MULT = 5;
	localparam int KP_SHIFT = 3;
	localparam int CMD_LIMIT = 2000;
	localparam int TIMEOUT = 200;

	logic                    us_clk;
	logic                    resetn;
	logic                    frame_valid;
	logic                    frame_ready;
	flight_pkg::rx_targets_t targets;
	flight_pkg::attitude_t   angles;
	logic                    gyro_valid;
	flight_pkg::gyro_t       gyro;
	logic                    cmd_valid;
	logic                    cmd_ready = 1'b1;
	flight_pkg::rate_cmd_t   cmd;
	flight_pkg::angle_err_t  errors;

	int  error_count = 0;
	bit  timed_out = 1'b0;
	int  ready_mode = 0;
	int  mode_q = 0;
	bit  rand_ready = 1'b1;
	bit  latency_check = 1'b0;
	int  heading = 0;
	int  gyro_count = 0;
	int  q_count = 0;

	flight_pkg::gyro_t      gyro_hist[$];
	flight_pkg::rate_cmd_t  exp_cmd_q[$];
	flight_pkg::angle_err_t exp_err_q[$];
	flight_pkg::rate_cmd_t  head_cmd;
	flight_pkg::angle_err_t head_err;

	tb_clock_gen clk_gen (
		.us_clk(us_clk),
		.resetn(resetn)
	);

	attitude_stabilizer #(
		.ANGLE_MULT (ANGLE_MULT),
		.ANGLE_SHIFT(ANGLE_SHIFT),
		.AVG_LOG2   (AVG_LOG2),
		.KP_MULT    (KP_MULT),
		.KP_SHIFT   (KP_SHIFT),
		.CMD_LIMIT  (CMD_LIMIT)
	) UUT (
		.us_clk     (us_clk),
		.resetn     (resetn),
		.frame_valid(frame_valid),
		.frame_ready(frame_ready),
		.targets    (targets),
		.angles     (angles),
		.gyro_valid (gyro_valid),
		.gyro       (gyro),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd        (cmd),
		.errors     (errors)
	);

	function automatic int clamp_int(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	// mean of the last samples on one axis (0 yaw, 1 pitch, 2 roll)
	function automatic int gyro_average(input int axis);
		int sum;
		sum = 0;
		foreach (gyro_hist[i]) begin
			if (axis == 0)
				sum += int'(gyro_hist[i].yaw);
			else if (axis == 1)
				sum += int'(gyro_hist[i].pitch);
			else
				sum += int'(gyro_hist[i].roll);
		end
		return sum >>> AVG_LOG2;
	endfunction

	function automatic int rate_setpoint(input int err);
		int scaled;
		scaled = clamp_int((err * ANGLE_MULT) >>> ANGLE_SHIFT, -32767, 32767);
		return clamp_int(scaled, -flight_pkg::RATE_LIMIT, flight_pkg::RATE_LIMIT);
	endfunction

	function automatic int rate_command(input int sp, input int avg);
		return clamp_int(((sp - avg) * KP_MULT) >>> KP_SHIFT, -CMD_LIMIT, CMD_LIMIT);
	endfunction

	function automatic int next_heading(input int h, input flight_pkg::rx_targets_t t,
		input flight_pkg::attitude_t a);
		int step;
		int full;
		full = flight_pkg::ANGLE_360 * 4;
		if (int'(t.throttle) < flight_pkg::THROTTLE_IDLE)
			return int'(a.yaw) * 4;
		step = h + int'(t.yaw) - flight_pkg::YAW_CENTER;
		if (step >= full)
			return step - full;
		if (step < 0)
			return step + full;
		return step;
	endfunction

	function automatic void expect_frame(input flight_pkg::rx_targets_t t,
		input flight_pkg::attitude_t a, input int hdg,
		output flight_pkg::rate_cmd_t c, output flight_pkg::angle_err_t e);
		int yt;
		int ya;
		int ey;
		yt = hdg >>> 2;
		ya = int'(a.yaw);
		// yaw error wraps across the 0/360 seam
		if (yt > flight_pkg::ANGLE_270 && ya < flight_pkg::ANGLE_90)
			ey = yt - ya - flight_pkg::ANGLE_360;
		else if (ya > flight_pkg::ANGLE_270 && yt < flight_pkg::ANGLE_90)
			ey = yt - ya + flight_pkg::ANGLE_360;
		else
			ey = yt - ya;
		e.yaw = flight_pkg::fixed_t'(clamp_int(ey, -32767, 32767));
		e.pitch = flight_pkg::fixed_t'(clamp_int(int'(t.pitch) * 4 - flight_pkg::MAP_OFFSET -
			int'(a.pitch), -32767, 32767));
		// roll comes in inverted
		e.roll = flight_pkg::fixed_t'(clamp_int(int'(t.roll) * 4 - flight_pkg::MAP_OFFSET +
			int'(a.roll), -32767, 32767));
		c.throttle = flight_pkg::fixed_t'(clamp_int(int'(t.throttle) * 16, 0,
			flight_pkg::THROTTLE_LIMIT));
		c.yaw = flight_pkg::fixed_t'(rate_command(rate_setpoint(int'(e.yaw)), gyro_average(0)));
		c.pitch = flight_pkg::fixed_t'(rate_command(rate_setpoint(int'(e.pitch)),
			gyro_average(1)));
		c.roll = flight_pkg::fixed_t'(rate_command(rate_setpoint(int'(e.roll)),
			gyro_average(2)));
	endfunction

	// reference model on the same edges as the DUT
	always @(posedge us_clk or negedge resetn) begin
		flight_pkg::rate_cmd_t c;
		flight_pkg::angle_err_t e;
		if (!resetn) begin
			heading = 0;
			gyro_count = 0;
			gyro_hist.delete();
			exp_cmd_q.delete();
			exp_err_q.delete();
		end else begin
			if (cmd_valid && cmd_ready && exp_cmd_q.size() > 0) begin
				void'(exp_cmd_q.pop_front());
				void'(exp_err_q.pop_front());
			end
			if (frame_valid && frame_ready) begin
				heading = next_heading(heading, targets, angles);
				expect_frame(targets, angles, heading, c, e);
				exp_cmd_q.push_back(c);
				exp_err_q.push_back(e);
			end
			if (gyro_valid) begin
				gyro_hist.push_back(gyro);
				if (gyro_hist.size() > (1 << AVG_LOG2))
					void'(gyro_hist.pop_front());
				gyro_count++;
			end
		end
		q_count = exp_cmd_q.size();
		if (q_count > 0) begin
			head_cmd = exp_cmd_q[0];
			head_err = exp_err_q[0];
		end
	end

	// ready pattern picked on the rising edge
	always @(posedge us_clk) begin
		mode_q = ready_mode;
		rand_ready = ($urandom % 4) != 0;
	end

	always @(negedge us_clk) begin
		if (mode_q == 0)
			cmd_ready = 1'b1;
		else if (mode_q == 1)
			cmd_ready = rand_ready;
		else
			cmd_ready = 1'b0;
	end

	a_cmd_expected: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid && cmd_ready |-> q_count > 0)
		else begin
			error_count++;
			$display("command handshake with no frame outstanding");
		end

	a_cmd_match: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid && cmd_ready && q_count > 0 |-> cmd == head_cmd)
		else begin
			error_count++;
			$display("error cmd expected %h actual %h", $sampled(head_cmd), $sampled(cmd));
		end

	a_err_match: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid && cmd_ready && q_count > 0 |-> errors == head_err)
		else begin
			error_count++;
			$display("error errors expected %h actual %h", $sampled(head_err), $sampled(errors));
		end

	a_cmd_stall: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid && !cmd_ready |=> $stable(cmd) && $stable(errors))
		else begin
			error_count++;
			$display("cmd or errors changed while cmd_ready was low");
		end

	a_no_early_cmd: assert property (@(posedge us_clk) disable iff (!resetn)
		cmd_valid |-> $past(gyro_count) >= 4)
		else begin
			error_count++;
			$display("cmd_valid rose before the gyro filter could be primed");
		end

	a_latency: assert property (@(posedge us_clk) disable iff (!resetn)
		frame_valid && frame_ready && latency_check |-> ##4 !cmd_valid ##1 cmd_valid)
		else begin
			error_count++;
			$display("cmd_valid did not rise 4 cycles after frame acceptance");
		end

	task automatic send_frame(input int thr, input int yaw, input int pitch, input int roll,
		input int ay, input int ap, input int ar);
		int cnt;
		if (timed_out)
			return;
		targets.throttle = flight_pkg::rx_val_t'(thr);
		targets.yaw = flight_pkg::rx_val_t'(yaw);
		targets.pitch = flight_pkg::rx_val_t'(pitch);
		targets.roll = flight_pkg::rx_val_t'(roll);
		angles.yaw = flight_pkg::fixed_t'(ay);
		angles.pitch = flight_pkg::fixed_t'(ap);
		angles.roll = flight_pkg::fixed_t'(ar);
		frame_valid = 1'b1;
		cnt = 0;
		while (!frame_ready && cnt < TIMEOUT) begin
			@(negedge us_clk);
			cnt++;
		end
		if (!frame_ready) begin
			$display("timeout: frame was never accepted");
			timed_out = 1'b1;
		end else begin
			// accepted on the rising edge in between
			@(negedge us_clk);
		end
		frame_valid = 1'b0;
	endtask

	task automatic random_frame();
		send_frame($urandom % 251, $urandom % 251, $urandom % 251, $urandom % 251,
			$urandom % 5760, int'($urandom % 2001) - 1000, int'($urandom % 2001) - 1000);
	endtask

	task automatic send_gyro(input int y, input int p, input int r);
		if (timed_out)
			return;
		gyro.yaw = flight_pkg::fixed_t'(y);
		gyro.pitch = flight_pkg::fixed_t'(p);
		gyro.roll = flight_pkg::fixed_t'(r);
		gyro_valid = 1'b1;
		@(negedge us_clk);
		gyro_valid = 1'b0;
	endtask

	// pipeline empty and every expected result seen
	task automatic wait_idle();
		int cnt;
		cnt = 0;
		while (!timed_out && !(frame_ready && !cmd_valid && q_count == 0) && cnt < TIMEOUT) begin
			@(negedge us_clk);
			cnt++;
		end
		if (!timed_out && cnt >= TIMEOUT) begin
			$display("timeout: pipeline did not drain");
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_frame_ready_low();
		int cnt;
		cnt = 0;
		while (!timed_out && frame_ready && cnt < TIMEOUT) begin
			@(negedge us_clk);
			cnt++;
		end
		if (!timed_out && frame_ready) begin
			$display("timeout: frame_ready stayed high under back-pressure");
			timed_out = 1'b1;
		end
	endtask

	task automatic finish_run();
		$display("run finished with %0d errors and %0d timeouts", error_count, timed_out);
		if (error_count == 0 && !timed_out)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	endtask

	initial begin
		int cnt;
		void'($urandom(32'hf26bd826));
		frame_valid = 1'b0;
		targets = '0;
		angles = '0;
		gyro_valid = 1'b0;
		gyro = '0;
		cnt = 0;
		while (resetn !== 1'b1 && cnt < TIMEOUT) begin
			@(negedge us_clk);
			cnt++;
		end
		@(negedge us_clk);
		a_reset_state: assert (frame_ready && !cmd_valid)
			else begin
				error_count++;
				$display("error frame_ready %h cmd_valid %h after reset", frame_ready, cmd_valid);
			end

		// frame held back until the filter is primed
		send_frame(5, 125, 150, 100, 0, 40, -40);
		repeat (4) send_gyro(0, 0, 0);
		wait_idle();

		// large gyro rates push the commands into saturation
		repeat (4) send_gyro(2000, -2000, 2000);
		send_frame(255, 125, 250, 0, 100, -2000, -2000);
		send_frame(250, 125, 0, 250, 200, 2000, 2000);
		send_frame(0, 125, 125, 125, 300, 0, 0);
		wait_idle();
		send_gyro(40, -24, 16);
		send_gyro(-8, 12, 60);
		send_gyro(100, -36, -20);
		send_gyro(4, 8, -44);
		send_frame(120, 125, 200, 40, 0, 300, -200);
		wait_idle();

		// heading lock then wraps downward and upward across the seam
		send_frame(5, 125, 125, 125, 20, 0, 0);
		repeat (3) send_frame(200, 0, 125, 125, 5740, 0, 0);
		send_frame(5, 125, 125, 125, 5700, 0, 0);
		repeat (3) send_frame(200, 250, 125, 125, 30, 0, 0);
		send_frame(150, 200, 125, 125, 5000, 0, 0);
		wait_idle();

		// back-pressure holds one result and one setpoint
		ready_mode = 2;
		@(negedge us_clk);
		random_frame();
		random_frame();
		wait_frame_ready_low();
		repeat (10) @(negedge us_clk);
		a_stall_state: assert (timed_out || (!frame_ready && cmd_valid))
			else begin
				error_count++;
				$display("error frame_ready %h cmd_valid %h under stall", frame_ready, cmd_valid);
			end
		ready_mode = 0;
		wait_idle();

		latency_check = 1'b1;
		repeat (4) random_frame();
		wait_idle();
		latency_check = 1'b0;

		ready_mode = 1;
		for (int i = 0; i < 40 && !timed_out; i++) begin
			random_frame();
			if (i % 8 == 7) begin
				wait_idle();
				send_gyro(int'($urandom % 801) - 400, int'($urandom % 801) - 400,
					int'($urandom % 801) - 400);
			end
		end
		ready_mode = 0;
		wait_idle();
		finish_run();
	end

endmodule

// File: list.f
src/flight_pkg.sv
src/angle_controller.sv
src/gyro_rate_filter.sv
src/rate_loop.sv
src/attitude_stabilizer.sv
testbench/tb_clock_gen.sv
testbench/attitude_stabilizer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the attitude stabilizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f \
	--top-module attitude_stabilizer_tb -o attitude_stabilizer_sim

./obj_dir/attitude_stabilizer_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
else
	exit 1
fi
